// ==== design/rv32_dbg_pkg.sv ====
`default_nettype none

package rv32_dbg_pkg;

    localparam int XLEN = 32;

    // major opcodes of the implemented subset
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // run control, resuming lasts exactly one cycle
    typedef enum logic [1:0] {
        DBG_RUNNING  = 2'd0,
        DBG_HALTED   = 2'd1,
        DBG_RESUMING = 2'd2
    } dbg_state_e;

    // abstract register addresses as seen by the debugger
    localparam logic [15:0] CSR_DCSR = 16'h07b0;
    localparam logic [15:0] CSR_DPC  = 16'h07b1;

    // x0..x31 map to GPR_BASE..GPR_BASE+31
    localparam logic [15:0] GPR_BASE = 16'h1000;

    // dcsr.cause values, field sits in bits 8:6
    localparam logic [2:0] CAUSE_EBREAK  = 3'd1;
    localparam logic [2:0] CAUSE_HALTREQ = 3'd3;

    // only writable bit of dcsr in this core
    localparam int DCSR_EBREAKM_BIT = 15;

endpackage

`default_nettype wire

// ==== design/core_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// execution side access to the register file
interface rf_if;
    logic [4:0]                    rs1_addr;
    logic [rv32_dbg_pkg::XLEN-1:0] rs1_data;
    logic                          we;
    logic [4:0]                    waddr;
    logic [rv32_dbg_pkg::XLEN-1:0] wdata;

    modport exec (output rs1_addr, we, waddr, wdata, input rs1_data);
    modport rf   (input rs1_addr, we, waddr, wdata, output rs1_data);
endinterface

// abstract register access from the debug module
interface dbg_ar_if;
    logic                          en;
    logic                          wr;
    logic [15:0]                   ad;
    logic [rv32_dbg_pkg::XLEN-1:0] wdata;
    // each responder returns its own read data, the top level selects
    logic [rv32_dbg_pkg::XLEN-1:0] gpr_rdata;
    logic [rv32_dbg_pkg::XLEN-1:0] csr_rdata;

    modport gpr (input en, wr, ad, wdata, output gpr_rdata);
    modport csr (input en, wr, ad, wdata, output csr_rdata);
endinterface

`default_nettype wire

// ==== design/core_dbg_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_dbg_fsm (
    input  wire logic                          clk,
    input  wire logic                          rst_i,
    input  wire logic                          haltreq_i,
    input  wire logic                          resumereq_i,
    input  wire logic                          ebreak_hit_i,
    input  wire logic [rv32_dbg_pkg::XLEN-1:0] pc_i,
    dbg_ar_if.csr                              ar,
    output logic                               run_o,
    output logic                               redirect_o,
    output logic [rv32_dbg_pkg::XLEN-1:0]      redirect_pc_o,
    output logic                               core_running_o,
    output logic                               core_halted_o,
    output logic                               core_resumeack_o
);

    rv32_dbg_pkg::dbg_state_e state_q;
    rv32_dbg_pkg::dbg_state_e state_d;

    logic                          ebreakm_q;
    logic [2:0]                    cause_q;
    logic [rv32_dbg_pkg::XLEN-1:0] dpc_q;
    logic [rv32_dbg_pkg::XLEN-1:0] dcsr;
    logic                          halt_evt;
    logic                          csr_wr_dcsr;
    logic                          csr_wr_dpc;

    // haltreq wins over ebreak, both only count while running
    assign halt_evt = (state_q == rv32_dbg_pkg::DBG_RUNNING) &&
                      (haltreq_i || (ebreak_hit_i && ebreakm_q));

    assign csr_wr_dcsr = ar.en && ar.wr && (ar.ad == rv32_dbg_pkg::CSR_DCSR);
    assign csr_wr_dpc  = ar.en && ar.wr && (ar.ad == rv32_dbg_pkg::CSR_DPC);

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv32_dbg_pkg::DBG_RUNNING: begin
                if (halt_evt) begin
                    state_d = rv32_dbg_pkg::DBG_HALTED;
                end
            end
            rv32_dbg_pkg::DBG_HALTED: begin
                if (resumereq_i) begin
                    state_d = rv32_dbg_pkg::DBG_RESUMING;
                end
            end
            default: state_d = rv32_dbg_pkg::DBG_RUNNING;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= rv32_dbg_pkg::DBG_RUNNING;
            ebreakm_q <= 1'b0;
            cause_q   <= 3'd0;
            dpc_q     <= '0;
        end else begin
            state_q <= state_d;
            if (csr_wr_dcsr) begin
                ebreakm_q <= ar.wdata[rv32_dbg_pkg::DCSR_EBREAKM_BIT];
            end
            // the instruction at pc did not retire, so it is where we go back to
            if (halt_evt) begin
                dpc_q   <= pc_i;
                cause_q <= haltreq_i ? rv32_dbg_pkg::CAUSE_HALTREQ
                                     : rv32_dbg_pkg::CAUSE_EBREAK;
            end else if (csr_wr_dpc) begin
                dpc_q <= ar.wdata;
            end
        end
    end

    always_comb begin
        dcsr = '0;
        dcsr[rv32_dbg_pkg::DCSR_EBREAKM_BIT] = ebreakm_q;
        dcsr[8:6] = cause_q;
    end

    always_comb begin
        case (ar.ad)
            rv32_dbg_pkg::CSR_DCSR: ar.csr_rdata = dcsr;
            rv32_dbg_pkg::CSR_DPC:  ar.csr_rdata = dpc_q;
            default:                ar.csr_rdata = '0;
        endcase
    end

    assign run_o         = (state_q == rv32_dbg_pkg::DBG_RUNNING) && !halt_evt;
    assign redirect_o    = (state_q == rv32_dbg_pkg::DBG_RESUMING);
    assign redirect_pc_o = dpc_q;

    assign core_running_o   = (state_q == rv32_dbg_pkg::DBG_RUNNING);
    assign core_halted_o    = (state_q == rv32_dbg_pkg::DBG_HALTED);
    assign core_resumeack_o = (state_q == rv32_dbg_pkg::DBG_RESUMING);

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter logic [rv32_dbg_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire logic                          clk,
    input  wire logic                          rst_i,
    input  wire logic [rv32_dbg_pkg::XLEN-1:0] inst_i,
    input  wire logic                          run_i,
    input  wire logic                          redirect_i,
    input  wire logic [rv32_dbg_pkg::XLEN-1:0] redirect_pc_i,
    rf_if.exec                                 rf,
    output logic [rv32_dbg_pkg::XLEN-1:0]      pc_o,
    output logic                               ebreak_hit_o
);

    rv32_dbg_pkg::opcode_e opcode;

    logic [4:0]                    rd;
    logic [2:0]                    funct3;
    logic [rv32_dbg_pkg::XLEN-1:0] imm_i;
    logic [rv32_dbg_pkg::XLEN-1:0] imm_u;
    logic [rv32_dbg_pkg::XLEN-1:0] imm_j;
    logic [rv32_dbg_pkg::XLEN-1:0] pc_q;
    logic [rv32_dbg_pkg::XLEN-1:0] pc_plus4;
    logic [rv32_dbg_pkg::XLEN-1:0] next_pc;
    logic [rv32_dbg_pkg::XLEN-1:0] wb_data;
    logic                          wb_en;

    assign opcode = rv32_dbg_pkg::opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];

    // immediate formats
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign pc_plus4 = pc_q + 32'd4;

    always_comb begin
        wb_en   = 1'b0;
        wb_data = '0;
        next_pc = pc_plus4;
        case (opcode)
            rv32_dbg_pkg::OPC_OP_IMM: begin
                // addi only, the other funct3 values retire as no-ops
                if (funct3 == 3'b000) begin
                    wb_en   = 1'b1;
                    wb_data = rf.rs1_data + imm_i;
                end
            end
            rv32_dbg_pkg::OPC_LUI: begin
                wb_en   = 1'b1;
                wb_data = imm_u;
            end
            rv32_dbg_pkg::OPC_JAL: begin
                wb_en   = 1'b1;
                wb_data = pc_plus4;
                next_pc = pc_q + imm_j;
            end
            default: begin
                // system and unknown encodings just advance the pc
            end
        endcase
    end

    // ebreak is funct12 = 1 with rs1, funct3 and rd all zero
    assign ebreak_hit_o = (opcode == rv32_dbg_pkg::OPC_SYSTEM) &&
                          (inst_i[31:20] == 12'h001) &&
                          (inst_i[19:7] == 13'd0);

    assign rf.rs1_addr = inst_i[19:15];
    assign rf.we       = run_i && wb_en;
    assign rf.waddr    = rd;
    assign rf.wdata    = wb_data;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (run_i) begin
            pc_q <= next_pc;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic clk,
    input  wire logic rst_i,
    rf_if.rf          rf,
    dbg_ar_if.gpr     ar
);

    logic [rv32_dbg_pkg::XLEN-1:0] regs [32];

    logic [15:0] gpr_off;
    logic [4:0]  gpr_idx;
    logic        gpr_hit;
    logic        dbg_we;

    // debugger view, x0..x31 sit right above GPR_BASE
    assign gpr_off = ar.ad - rv32_dbg_pkg::GPR_BASE;
    assign gpr_idx = gpr_off[4:0];
    assign gpr_hit = (ar.ad >= rv32_dbg_pkg::GPR_BASE) && (gpr_off < 16'd32);
    assign dbg_we  = ar.en && ar.wr && gpr_hit;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // both ports never target the same register, debug writes happen while halted
            if (rf.we && (rf.waddr != 5'd0)) begin
                regs[rf.waddr] <= rf.wdata;
            end
            if (dbg_we && (gpr_idx != 5'd0)) begin
                regs[gpr_idx] <= ar.wdata;
            end
        end
    end

    assign rf.rs1_data = (rf.rs1_addr == 5'd0) ? '0 : regs[rf.rs1_addr];

    always_comb begin
        if (gpr_hit && (gpr_idx != 5'd0)) begin
            ar.gpr_rdata = regs[gpr_idx];
        end else begin
            ar.gpr_rdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv32i.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32i #(
    parameter logic [rv32_dbg_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire logic                          clk,
    input  wire logic                          rst_i,

    // instruction fetch
    output logic [rv32_dbg_pkg::XLEN-1:0]      current_pc_o,
    input  wire logic [rv32_dbg_pkg::XLEN-1:0] inst_i,

    // run control
    output logic                               core_running_o,
    output logic                               core_halted_o,
    output logic                               core_resumeack_o,
    input  wire logic                          dbg_haltreq_i,
    input  wire logic                          dbg_resumereq_i,

    // abstract register access
    input  wire logic                          dbg_ar_en_i,
    input  wire logic                          dbg_ar_wr_i,
    input  wire logic [15:0]                   dbg_ar_ad_i,
    input  wire logic [rv32_dbg_pkg::XLEN-1:0] dbg_ar_do_i,
    output logic [rv32_dbg_pkg::XLEN-1:0]      dbg_ar_di_o,
    output logic                               dbg_ar_done_o
);

    logic                          run;
    logic                          redirect;
    logic [rv32_dbg_pkg::XLEN-1:0] redirect_pc;
    logic                          ebreak_hit;
    logic [rv32_dbg_pkg::XLEN-1:0] pc;

    rf_if     rf_bus ();
    dbg_ar_if ar_bus ();

    assign ar_bus.en    = dbg_ar_en_i;
    assign ar_bus.wr    = dbg_ar_wr_i;
    assign ar_bus.ad    = dbg_ar_ad_i;
    assign ar_bus.wdata = dbg_ar_do_i;

    core_dbg_fsm u_core_dbg_fsm (
        .clk              (clk),
        .rst_i            (rst_i),
        .haltreq_i        (dbg_haltreq_i),
        .resumereq_i      (dbg_resumereq_i),
        .ebreak_hit_i     (ebreak_hit),
        .pc_i             (pc),
        .ar               (ar_bus),
        .run_o            (run),
        .redirect_o       (redirect),
        .redirect_pc_o    (redirect_pc),
        .core_running_o   (core_running_o),
        .core_halted_o    (core_halted_o),
        .core_resumeack_o (core_resumeack_o)
    );

    exec_unit #(
        .RESET_PC (RESET_PC)
    ) u_exec_unit (
        .clk           (clk),
        .rst_i         (rst_i),
        .inst_i        (inst_i),
        .run_i         (run),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .rf            (rf_bus),
        .pc_o          (pc),
        .ebreak_hit_o  (ebreak_hit)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .rst_i (rst_i),
        .rf    (rf_bus),
        .ar    (ar_bus)
    );

    assign current_pc_o = pc;

    // debug csrs first, then the gpr window, anything else reads as zero
    always_comb begin
        if ((dbg_ar_ad_i == rv32_dbg_pkg::CSR_DCSR) || (dbg_ar_ad_i == rv32_dbg_pkg::CSR_DPC)) begin
            dbg_ar_di_o = ar_bus.csr_rdata;
        end else if ((dbg_ar_ad_i >= rv32_dbg_pkg::GPR_BASE) &&
                     (dbg_ar_ad_i <= rv32_dbg_pkg::GPR_BASE + 16'd31)) begin
            dbg_ar_di_o = ar_bus.gpr_rdata;
        end else begin
            dbg_ar_di_o = '0;
        end
    end

    assign dbg_ar_done_o = dbg_ar_en_i;

endmodule

`default_nettype wire

// ==== include/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// program image with word i at RESET_PC + 4*i
// the testbench fills in a random immediate for every addi
localparam int TB_PROG_LEN = 12;
localparam logic [31:0] TB_PROG [TB_PROG_LEN] = '{
    32'h00000093,   // addi x1, x0, imm
    32'h00008113,   // addi x2, x1, imm
    32'h123451b7,   // lui  x3, 0x12345
    32'h0080026f,   // jal  x4, +8
    32'h00000293,   // addi x5, x0, imm (jumped over)
    32'h00010313,   // addi x6, x2, imm
    32'habcde3b7,   // lui  x7, 0xabcde
    32'h00100073,   // ebreak met while ebreakm is still clear
    32'h00030413,   // addi x8, x6, imm
    32'h00100073,   // ebreak that halts once ebreakm is set
    32'h00008493,   // addi x9, x1, imm reading the debugger's x1
    32'h0000006f    // jal x0, 0 spins in place
};

typedef enum logic [2:0] {
    CMD_HALT,
    CMD_RESUME,
    CMD_SET_EBREAKM,
    CMD_READ_GPR,
    CMD_WRITE_GPR,
    CMD_WRITE_DPC,
    CMD_RUN
} tb_cmd_e;

// addr is the abstract address and data the write value or the cycle count
typedef struct packed {
    tb_cmd_e     cmd;
    logic [15:0] addr;
    logic [31:0] data;
} tb_cmd_t;

localparam int TB_CMD_LEN = 20;
localparam tb_cmd_t TB_CMDS [TB_CMD_LEN] = '{
    '{CMD_RUN,         16'h0000,                       32'd5},
    '{CMD_HALT,        16'h0000,                       32'd0},
    '{CMD_READ_GPR,    rv32_dbg_pkg::GPR_BASE + 16'd1, 32'd0},
    '{CMD_READ_GPR,    rv32_dbg_pkg::GPR_BASE + 16'd2, 32'd0},
    '{CMD_READ_GPR,    rv32_dbg_pkg::GPR_BASE + 16'd3, 32'd0},
    '{CMD_READ_GPR,    rv32_dbg_pkg::GPR_BASE + 16'd4, 32'd0},
    '{CMD_WRITE_GPR,   rv32_dbg_pkg::GPR_BASE,         32'hdeadbeef},
    '{CMD_READ_GPR,    rv32_dbg_pkg::GPR_BASE,         32'd0},
    '{CMD_READ_GPR,    16'h2000,                       32'd0},
    '{CMD_RESUME,      16'h0000,                       32'd0},
    '{CMD_RUN,         16'h0000,                       32'd3},
    '{CMD_HALT,        16'h0000,                       32'd0},
    '{CMD_SET_EBREAKM, rv32_dbg_pkg::CSR_DCSR,         32'd1},
    '{CMD_RESUME,      16'h0000,                       32'd0},
    '{CMD_RUN,         16'h0000,                       32'd4},
    '{CMD_WRITE_GPR,   rv32_dbg_pkg::GPR_BASE + 16'd1, 32'h00000100},
    '{CMD_WRITE_DPC,   rv32_dbg_pkg::CSR_DPC,          32'h00000028},
    '{CMD_RESUME,      16'h0000,                       32'd0},
    '{CMD_RUN,         16'h0000,                       32'd4},
    '{CMD_HALT,        16'h0000,                       32'd0}
};

`endif

// ==== tests/tb_rv32i.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i;

    localparam logic [31:0] RESET_PC    = 32'h0000_0000;
    localparam int          CLK_PERIOD  = 4;
    localparam logic [31:0] NOP_INSN    = 32'h0000_0013;
    localparam logic [31:0] EBREAK_INSN = 32'h0010_0073;

    `include "tb_vectors.svh"

    logic                          clk;
    logic                          rst_i;
    logic [rv32_dbg_pkg::XLEN-1:0] inst;
    logic [rv32_dbg_pkg::XLEN-1:0] current_pc;
    logic                          haltreq;
    logic                          resumereq;
    logic                          ar_en;
    logic                          ar_wr;
    logic [15:0]                   ar_ad;
    logic [rv32_dbg_pkg::XLEN-1:0] ar_do;
    logic [rv32_dbg_pkg::XLEN-1:0] ar_di;
    logic                          ar_done;
    logic                          running;
    logic                          halted;
    logic                          resumeack;

    // instruction memory, patched with random addi immediates at time zero
    logic [31:0] imem [TB_PROG_LEN];
    logic [31:0] fetch_idx;
    logic [31:0] rng_state;

    // model of the core as the debugger sees it
    rv32_dbg_pkg::dbg_state_e m_state;
    logic [31:0]              m_pc;
    logic [31:0]              m_dpc;
    logic [2:0]               m_cause;
    logic                     m_ebreakm;
    logic [31:0]              m_regs [32];
    logic                     halt_seen;

    rv32i #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk              (clk),
        .rst_i            (rst_i),
        .current_pc_o     (current_pc),
        .inst_i           (inst),
        .core_running_o   (running),
        .core_halted_o    (halted),
        .core_resumeack_o (resumeack),
        .dbg_haltreq_i    (haltreq),
        .dbg_resumereq_i  (resumereq),
        .dbg_ar_en_i      (ar_en),
        .dbg_ar_wr_i      (ar_wr),
        .dbg_ar_ad_i      (ar_ad),
        .dbg_ar_do_i      (ar_do),
        .dbg_ar_di_o      (ar_di),
        .dbg_ar_done_o    (ar_done)
    );

    // fetch outside the image returns a nop
    assign fetch_idx = (current_pc - RESET_PC) >> 2;
    assign inst      = (fetch_idx < TB_PROG_LEN) ? imem[fetch_idx] : NOP_INSN;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] model_fetch(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        if (idx < TB_PROG_LEN) begin
            return imem[idx];
        end
        return NOP_INSN;
    endfunction

    function automatic logic in_gpr_range(input logic [15:0] addr);
        return (addr >= rv32_dbg_pkg::GPR_BASE) && (addr <= rv32_dbg_pkg::GPR_BASE + 16'd31);
    endfunction

    // what the debugger should read back at an abstract address
    function automatic logic [31:0] ar_expected(input logic [15:0] addr);
        logic [31:0] v;
        v = '0;
        if (addr == rv32_dbg_pkg::CSR_DCSR) begin
            v[rv32_dbg_pkg::DCSR_EBREAKM_BIT] = m_ebreakm;
            v[8:6] = m_cause;
        end else if (addr == rv32_dbg_pkg::CSR_DPC) begin
            v = m_dpc;
        end else if (in_gpr_range(addr)) begin
            v = m_regs[addr - rv32_dbg_pkg::GPR_BASE];
        end
        return v;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [rv32_dbg_pkg::XLEN-1:0] got,
                              input logic [rv32_dbg_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_state(input rv32_dbg_pkg::dbg_state_e exp);
        logic [2:0] got;
        logic [2:0] want;
        got  = {running, halted, resumeack};
        want = {exp == rv32_dbg_pkg::DBG_RUNNING, exp == rv32_dbg_pkg::DBG_HALTED,
                exp == rv32_dbg_pkg::DBG_RESUMING};
        if (got !== want) begin
            stop_with_failure($sformatf("FAILED running_halted_resumeack got %h expected %h",
                                        got, want));
        end
    endtask

    task automatic model_retire(input logic [31:0] w);
        logic [4:0]  rd;
        logic [31:0] nxt;
        rd  = w[11:7];
        nxt = m_pc + 32'd4;
        case (rv32_dbg_pkg::opcode_e'(w[6:0]))
            rv32_dbg_pkg::OPC_OP_IMM: begin
                if (w[14:12] == 3'b000) begin
                    m_regs[rd] = m_regs[w[19:15]] + {{20{w[31]}}, w[31:20]};
                end
            end
            rv32_dbg_pkg::OPC_LUI: m_regs[rd] = {w[31:12], 12'b0};
            rv32_dbg_pkg::OPC_JAL: begin
                m_regs[rd] = nxt;
                nxt = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
            end
        endcase
        m_regs[0] = '0;
        m_pc = nxt;
    endtask

    // one rising edge of the model, halt request beats ebreak
    task automatic model_edge(input logic hreq, input logic rreq);
        case (m_state)
            rv32_dbg_pkg::DBG_RUNNING: begin
                if (hreq || ((model_fetch(m_pc) == EBREAK_INSN) && m_ebreakm)) begin
                    m_cause   = hreq ? rv32_dbg_pkg::CAUSE_HALTREQ : rv32_dbg_pkg::CAUSE_EBREAK;
                    m_dpc     = m_pc;
                    m_state   = rv32_dbg_pkg::DBG_HALTED;
                    halt_seen = 1'b1;
                end else begin
                    model_retire(model_fetch(m_pc));
                end
            end
            rv32_dbg_pkg::DBG_HALTED: begin
                if (rreq) begin
                    m_state = rv32_dbg_pkg::DBG_RESUMING;
                end
            end
            default: begin
                m_pc    = m_dpc;
                m_state = rv32_dbg_pkg::DBG_RUNNING;
            end
        endcase
    endtask

    task automatic advance_clock();
        model_edge(haltreq, resumereq);
        @(negedge clk);
        check_state(m_state);
        check_word("current_pc_o", current_pc, m_pc);
        check_flag("dbg_ar_done_o", ar_done, ar_en);
    endtask

    // one abstract access, held for a full cycle
    task automatic ar_access(input logic wr, input logic [15:0] addr, input logic [31:0] wdata);
        ar_en = 1'b1;
        ar_wr = wr;
        ar_ad = addr;
        ar_do = wdata;
        advance_clock();
        if (!wr) begin
            check_word("dbg_ar_di_o", ar_di, ar_expected(addr));
        end else if (addr == rv32_dbg_pkg::CSR_DCSR) begin
            m_ebreakm = wdata[rv32_dbg_pkg::DCSR_EBREAKM_BIT];
        end else if (addr == rv32_dbg_pkg::CSR_DPC) begin
            m_dpc = wdata;
        end else if (in_gpr_range(addr) && (addr != rv32_dbg_pkg::GPR_BASE)) begin
            m_regs[addr - rv32_dbg_pkg::GPR_BASE] = wdata;
        end
        ar_en = 1'b0;
        ar_wr = 1'b0;
    endtask

    initial begin
        tb_cmd_t cmd;
        rst_i     = 1'b1;
        haltreq   = 1'b0;
        resumereq = 1'b0;
        ar_en     = 1'b0;
        ar_wr     = 1'b0;
        ar_ad     = '0;
        ar_do     = '0;
        halt_seen = 1'b0;
        rng_state = 32'd83;
        for (int i = 0; i < TB_PROG_LEN; i++) begin
            imem[i] = TB_PROG[i];
            if ((imem[i][6:0] == rv32_dbg_pkg::OPC_OP_IMM) && (imem[i][14:12] == 3'b000)) begin
                rng_state = xorshift32(rng_state);
                imem[i][31:20] = rng_state[11:0];
            end
        end
        m_state   = rv32_dbg_pkg::DBG_RUNNING;
        m_pc      = RESET_PC;
        m_dpc     = '0;
        m_cause   = '0;
        m_ebreakm = 1'b0;
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        check_state(rv32_dbg_pkg::DBG_RUNNING);
        check_word("current_pc_o", current_pc, RESET_PC);

        for (int i = 0; i < TB_CMD_LEN; i++) begin
            cmd = TB_CMDS[i];
            case (cmd.cmd)
                CMD_RUN: repeat (cmd.data) advance_clock();
                CMD_HALT: begin
                    haltreq = 1'b1;
                    advance_clock();
                    haltreq = 1'b0;
                end
                CMD_RESUME: begin
                    resumereq = 1'b1;
                    advance_clock();
                    resumereq = 1'b0;
                end
                CMD_SET_EBREAKM: begin
                    ar_access(1'b1, cmd.addr,
                              {31'b0, cmd.data[0]} << rv32_dbg_pkg::DCSR_EBREAKM_BIT);
                    ar_access(1'b0, cmd.addr, '0);
                end
                CMD_READ_GPR: ar_access(1'b0, cmd.addr, '0);
                CMD_WRITE_GPR, CMD_WRITE_DPC: ar_access(1'b1, cmd.addr, cmd.data);
                default: stop_with_failure("the command table holds an unknown command");
            endcase
            // a fresh halt must leave dpc and the cause behind
            if (halt_seen) begin
                halt_seen = 1'b0;
                ar_access(1'b0, rv32_dbg_pkg::CSR_DPC, '0);
                ar_access(1'b0, rv32_dbg_pkg::CSR_DCSR, '0);
            end
        end

        // sweep every gpr once the core has stopped
        if (m_state == rv32_dbg_pkg::DBG_HALTED) begin
            for (int r = 0; r < 32; r++) begin
                ar_access(1'b0, rv32_dbg_pkg::GPR_BASE + 16'(r), '0);
            end
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

    // limit is the table's run cycles plus some slack
    initial begin
        int total;
        total = 100;
        for (int i = 0; i < TB_CMD_LEN; i++) begin
            if (TB_CMDS[i].cmd == CMD_RUN) begin
                total += int'(TB_CMDS[i].data);
            end
        end
        #(total * CLK_PERIOD);
        stop_with_failure("watchdog expired, the test hung");
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
design/rv32_dbg_pkg.sv
design/core_ifs.sv
design/core_dbg_fsm.sv
design/exec_unit.sv
design/reg_file.sv
design/rv32i.sv
tests/tb_rv32i.sv
